// ==== src/mem_map_pkg.sv ====
// memory map package: download and SDRAM widths, floppy image sizes, region offsets
package mem_map_pkg;

	// ----------------------------------------------------------------------
	// widths that carry a meaning
	// ----------------------------------------------------------------------
	typedef logic [7:0]  byte_t;       // one download byte
	typedef logic [23:0] dl_addr_t;    // download byte address
	typedef logic [20:0] word_addr_t;  // 16 bit word address, 4 MB space
	typedef logic [24:0] sdram_addr_t; // full SDRAM word address
	typedef logic [15:0] word_t;

	// upper SDRAM address bits above a word address
	localparam int REGION_W = $bits(sdram_addr_t) - $bits(word_addr_t);

	// download index codes
	localparam logic [4:0] IDX_ROM      = 5'd0;
	localparam logic [4:0] IDX_DISK_INT = 5'd1;
	localparam logic [4:0] IDX_DISK_EXT = 5'd2;

	// disk images sit behind the os rom
	localparam word_addr_t DISK_INT_BASE = 21'h080000; // 512k words
	localparam word_addr_t DISK_EXT_BASE = 21'h100000; // 1M words

	// last word of a good image, 819200 and 409600 bytes
	localparam logic [22:0] DS_LAST_WORD = 23'd409599;
	localparam logic [22:0] SS_LAST_WORD = 23'd204799;

	localparam logic [REGION_W-1:0] DL_REGION  = 4'b0001;
	localparam logic [REGION_W-1:0] ROM_REGION = 4'b0001; // rom lives where it was loaded

	localparam word_t READ_BLANK = 16'hffff; // keeps the screen black while loading

endpackage

// ==== src/cpu_bus_pkg.sv ====
// 68000 bus package: function codes, address areas, configuration and reset hold
package cpu_bus_pkg;

	// ----------------------------------------------------------------------
	// bus fields
	// ----------------------------------------------------------------------
	typedef logic [2:0] fc_t;   // function code
	typedef logic [2:0] area_t; // address bits 23:21

	localparam fc_t FC_INT_ACK = 3'd7; // cpu space, interrupt acknowledge

	// autovector and 6522/peripheral area at the top of the map
	localparam area_t AREA_VPA = 3'd7;

	// ----------------------------------------------------------------------
	// configuration choices from the menu
	// ----------------------------------------------------------------------
	typedef logic       mem_cfg_t; // 1MB or 4MB
	typedef logic [1:0] cpu_cfg_t; // 68000, 68010, 68020

	// roughly 8 ms of extra reset at an 8 MHz tick
	localparam logic [15:0] RESET_HOLD = 16'd65535;

endpackage

// ==== src/download_port.sv ====
// download port: places rom and disk image bytes into memory words with a held write strobe
`timescale 1ns/1ps

module download_port (
	input  logic                    clk32,
	input  logic                    rst,
	input  logic                    dl_busy,
	input  logic                    dl_slot,
	input  logic [4:0]              dl_index,
	input  mem_map_pkg::dl_addr_t   dl_addr,
	input  mem_map_pkg::byte_t      dl_data,
	input  logic                    dl_wr,
	output logic                    dl_active,
	output logic                    rom_loading,
	output mem_map_pkg::word_addr_t dl_word,
	output mem_map_pkg::word_t      dl_din,
	output logic [1:0]              dl_ds,
	output logic                    dl_we
);

	logic                    active_d;    // dl_active one edge ago
	logic                    cycle_end;   // falling edge of the download cycle
	logic                    wr_pending;
	mem_map_pkg::word_addr_t byte_word;

	assign dl_active   = dl_busy & dl_slot;
	assign rom_loading = dl_busy & (dl_index == mem_map_pkg::IDX_ROM);
	assign cycle_end   = active_d & ~dl_active;

	// ----------------------------------------------------------------------
	// address and lane mapping
	// ----------------------------------------------------------------------
	assign byte_word = dl_addr[21:1]; // addr counts bytes

	always_comb begin
		case (dl_index)
			mem_map_pkg::IDX_ROM:      dl_word = byte_word;
			mem_map_pkg::IDX_DISK_INT: dl_word = byte_word + mem_map_pkg::DISK_INT_BASE;
			default:                   dl_word = byte_word + mem_map_pkg::DISK_EXT_BASE;
		endcase
	end

	assign dl_din = {dl_data, dl_data};       // same byte on both lanes
	assign dl_ds  = {~dl_addr[0], dl_addr[0]}; // even byte is the upper lane

	// write flag lives until the memory has seen a whole download cycle
	always_ff @(posedge clk32) begin
		if (rst) begin
			active_d   <= 1'b0;
			wr_pending <= 1'b0;
		end else begin
			active_d <= dl_active;
			if (dl_wr)
				wr_pending <= 1'b1; // a new byte wins over the clear
			else if (cycle_end)
				wr_pending <= 1'b0;
		end
	end

	assign dl_we = wr_pending & dl_active;

	a_we_in_cycle: assert property (@(posedge clk32) disable iff (rst)
		dl_we |-> (dl_busy && dl_slot));

endmodule

// ==== src/disk_image_detect.sv ====
// floppy image detection latching single or double sided per drive when a download ends
`timescale 1ns/1ps

module disk_image_detect (
	input  logic                  clk32,
	input  logic                  rst,
	input  logic                  dl_busy,
	input  logic [4:0]            dl_index,
	input  mem_map_pkg::dl_addr_t dl_addr,
	input  logic [1:0]            eject,
	output logic [1:0]            inserted,
	output logic [1:0]            double_sided
);

	logic        busy_d;
	logic        dl_end;
	logic [1:0]  drive_sel;    // bit 0 internal, bit 1 external
	logic [22:0] last_word;
	logic        size_ds;
	logic        size_ss;
	logic [1:0]  ds_flag;
	logic [1:0]  ss_flag;

	assign dl_end    = busy_d & ~dl_busy;
	assign drive_sel = {dl_index == mem_map_pkg::IDX_DISK_EXT,
		dl_index == mem_map_pkg::IDX_DISK_INT};

	// final word address of the image
	assign last_word = dl_addr[23:1];
	assign size_ds   = (last_word == mem_map_pkg::DS_LAST_WORD);
	assign size_ss   = (last_word == mem_map_pkg::SS_LAST_WORD);

	always_ff @(posedge clk32) begin
		if (rst) begin
			busy_d  <= 1'b0;
			ds_flag <= 2'b00;
			ss_flag <= 2'b00;
		end else begin
			busy_d <= dl_busy;
			for (int d = 0; d < 2; d++) begin
				if (eject[d]) begin
					ds_flag[d] <= 1'b0; // os ejected the disk
					ss_flag[d] <= 1'b0;
				end else if (dl_end && drive_sel[d]) begin
					ds_flag[d] <= size_ds; // unknown size clears both
					ss_flag[d] <= size_ss;
				end
			end
		end
	end

	assign inserted     = ds_flag | ss_flag;
	assign double_sided = ds_flag;

	a_one_kind: assert property (@(posedge clk32) disable iff (rst)
		(ds_flag & ss_flag) == 2'b00);

endmodule

// ==== src/reset_stretch.sv ====
// reset stretcher: holds the system in reset for a fixed count after any reset source
`timescale 1ns/1ps

module reset_stretch (
	input  logic                  clk32,
	input  logic                  rst,
	input  logic                  tick,
	input  logic                  pll_locked,
	input  logic                  osd_reset,
	input  logic                  button_reset,
	input  logic                  rom_loading,
	input  cpu_bus_pkg::mem_cfg_t mem_cfg,
	input  cpu_bus_pkg::cpu_cfg_t cpu_cfg,
	input  logic                  cpu_reset_out_n,
	output logic                  system_reset_n
);

	cpu_bus_pkg::mem_cfg_t last_mem;
	cpu_bus_pkg::cpu_cfg_t last_cpu;
	logic [15:0]           hold_cnt;
	logic                  cfg_change;
	logic                  any_source;

	assign cfg_change = (last_mem != mem_cfg) || (last_cpu != cpu_cfg);

	// everything that restarts the machine
	assign any_source = ~pll_locked | osd_reset | button_reset | rom_loading |
		cfg_change | ~cpu_reset_out_n; // reset instruction from the cpu

	always_ff @(posedge clk32) begin
		if (rst) begin
			last_mem <= mem_cfg;
			last_cpu <= cpu_cfg;
			hold_cnt <= cpu_bus_pkg::RESET_HOLD;
		end else if (tick) begin
			last_mem <= mem_cfg;
			last_cpu <= cpu_cfg;
			if (any_source)
				hold_cnt <= cpu_bus_pkg::RESET_HOLD;
			else if (hold_cnt != 16'd0)
				hold_cnt <= hold_cnt - 16'd1;
		end
	end

	assign system_reset_n = (hold_cnt == 16'd0);

endmodule

// ==== src/bus_ack.sv ====
// bus acknowledge: DTACK and VPA for the 68000, turbo speed latch and cpu clock enables
`timescale 1ns/1ps

module bus_ack (
	input  logic               clk32,
	input  logic               rst,
	input  logic               cpu_reset_n,
	input  logic               as_n,
	input  cpu_bus_pkg::fc_t   fc,
	input  cpu_bus_pkg::area_t area,
	input  logic               cpu_slot,
	input  logic               select_ram,
	input  logic               select_rom,
	input  logic               turbo,
	input  logic               en8_p,
	input  logic               en8_n,
	input  logic               en16_p,
	input  logic               en16_n,
	output logic               dtack_n,
	output logic               vpa_n,
	output logic               cpu_en_p,
	output logic               cpu_en_n
);

	logic cpu_slot_d;
	logic slot_start;   // first clock of a cpu bus slot
	logic dtack_en;
	logic speed;        // 1 = 16 MHz
	logic int_ack;
	logic vpa_area;

	assign slot_start = cpu_slot & ~cpu_slot_d;

	// ----------------------------------------------------------------------
	// turbo dtack enable and speed latch
	// ----------------------------------------------------------------------
	always_ff @(posedge clk32) begin
		if (rst) begin
			cpu_slot_d <= 1'b0;
			dtack_en   <= 1'b0;
			speed      <= 1'b0;
		end else if (!cpu_reset_n) begin
			cpu_slot_d <= cpu_slot;
			dtack_en   <= 1'b0;
			speed      <= turbo;
		end else begin
			cpu_slot_d <= cpu_slot;
			if (as_n)
				dtack_en <= 1'b0;
			else if (slot_start || (!select_ram && !select_rom))
				dtack_en <= 1'b1; // memory access lines up with a slot

			// switch only between bus cycles and on a common phase
			if (as_n && en8_n && en16_n)
				speed <= turbo;
		end
	end

	// ----------------------------------------------------------------------
	// acknowledges
	// ----------------------------------------------------------------------
	assign int_ack  = (fc == cpu_bus_pkg::FC_INT_ACK);
	assign vpa_area = (area == cpu_bus_pkg::AREA_VPA);

	assign vpa_n   = int_ack ? 1'b0 : ~(~as_n & vpa_area); // autovector
	assign dtack_n = ~(~as_n & ~vpa_area & ~int_ack) | (turbo & ~dtack_en);

	assign cpu_en_p = speed ? en16_p : en8_p;
	assign cpu_en_n = speed ? en16_n : en8_n;

	a_ack_excl: assert property (@(posedge clk32) disable iff (rst)
		!(!dtack_n && !vpa_n));

endmodule

// ==== src/mem_port_mux.sv ====
// memory port mux: picks download or cpu request for the SDRAM and shapes read data
`timescale 1ns/1ps

module mem_port_mux (
	input  logic                     dl_active,
	input  mem_map_pkg::word_addr_t  dl_word,
	input  mem_map_pkg::word_t       dl_din,
	input  logic [1:0]               dl_ds,
	input  logic                     dl_we,
	input  mem_map_pkg::word_addr_t  mem_word,
	input  logic                     mem_byte_odd,
	input  logic                     rom_oe_n,
	input  logic                     ram_oe_n,
	input  logic                     ram_we_n,
	input  logic                     uds_n,
	input  logic                     lds_n,
	input  mem_map_pkg::word_t       cpu_dout,
	input  logic [1:0]               disk_ack,
	input  mem_map_pkg::word_t       sdram_dout,
	output mem_map_pkg::sdram_addr_t sdram_addr,
	output mem_map_pkg::word_t       sdram_din,
	output logic [1:0]               sdram_ds,
	output logic                     sdram_we,
	output logic                     sdram_oe,
	output mem_map_pkg::word_t       read_data
);

	logic [mem_map_pkg::REGION_W-1:0] cpu_region;
	mem_map_pkg::word_t               disk_byte; // byte wide image, doubled

	assign cpu_region = rom_oe_n ? '0 : mem_map_pkg::ROM_REGION;

	// ----------------------------------------------------------------------
	// request side
	// ----------------------------------------------------------------------
	always_comb begin
		if (dl_active) begin
			sdram_addr = {mem_map_pkg::DL_REGION, dl_word};
			sdram_din  = dl_din;
			sdram_ds   = dl_ds;
			sdram_we   = dl_we;
			sdram_oe   = 1'b0; // writes only
		end else begin
			sdram_addr = {cpu_region, mem_word};
			sdram_din  = cpu_dout;
			sdram_ds   = {~uds_n, ~lds_n};
			sdram_we   = ~ram_we_n;
			sdram_oe   = ~ram_oe_n | ~rom_oe_n;
		end
	end

	// ----------------------------------------------------------------------
	// read side
	// ----------------------------------------------------------------------
	assign disk_byte = mem_byte_odd ? {sdram_dout[7:0], sdram_dout[7:0]}
		: {sdram_dout[15:8], sdram_dout[15:8]};

	always_comb begin
		if (dl_active)
			read_data = mem_map_pkg::READ_BLANK;
		else if (|disk_ack)
			read_data = disk_byte; // floppy controller reads bytes
		else
			read_data = sdram_dout;
	end

endmodule

// ==== src/plus_glue_top.sv ====
// glue top: download, disk detect, reset, bus acknowledge and memory port of the core
`timescale 1ns/1ps

module plus_glue_top (
	input  logic                     clk32,
	input  logic                     rst,
	// download source
	input  logic                     dl_busy,
	input  logic                     dl_slot,
	input  logic [4:0]               dl_index,
	input  mem_map_pkg::dl_addr_t    dl_addr,
	input  mem_map_pkg::byte_t       dl_data,
	input  logic                     dl_wr,
	// floppy
	input  logic [1:0]               eject,
	output logic [1:0]               inserted,
	output logic [1:0]               double_sided,
	// reset sources
	input  logic                     tick,
	input  logic                     pll_locked,
	input  logic                     osd_reset,
	input  logic                     button_reset,
	input  cpu_bus_pkg::mem_cfg_t    mem_cfg,
	input  cpu_bus_pkg::cpu_cfg_t    cpu_cfg,
	input  logic                     cpu_reset_out_n,
	output logic                     system_reset_n,
	// cpu bus
	input  logic                     cpu_reset_n,
	input  logic                     as_n,
	input  cpu_bus_pkg::fc_t         fc,
	input  cpu_bus_pkg::area_t       area,
	input  logic                     cpu_slot,
	input  logic                     select_ram,
	input  logic                     select_rom,
	input  logic                     turbo,
	input  logic                     en8_p,
	input  logic                     en8_n,
	input  logic                     en16_p,
	input  logic                     en16_n,
	output logic                     dtack_n,
	output logic                     vpa_n,
	output logic                     cpu_en_p,
	output logic                     cpu_en_n,
	// memory request from the address decoder
	input  mem_map_pkg::word_addr_t  mem_word,
	input  logic                     mem_byte_odd,
	input  logic                     rom_oe_n,
	input  logic                     ram_oe_n,
	input  logic                     ram_we_n,
	input  logic                     uds_n,
	input  logic                     lds_n,
	input  mem_map_pkg::word_t       cpu_dout,
	input  logic [1:0]               disk_ack,
	// sdram port
	input  mem_map_pkg::word_t       sdram_dout,
	output mem_map_pkg::sdram_addr_t sdram_addr,
	output mem_map_pkg::word_t       sdram_din,
	output logic [1:0]               sdram_ds,
	output logic                     sdram_we,
	output logic                     sdram_oe,
	output mem_map_pkg::word_t       read_data
);

	logic                    dl_active;
	logic                    rom_loading;
	mem_map_pkg::word_addr_t dl_word;
	mem_map_pkg::word_t      dl_din;
	logic [1:0]              dl_ds;
	logic                    dl_we;

	download_port i_download_port (
		.clk32       (clk32),
		.rst         (rst),
		.dl_busy     (dl_busy),
		.dl_slot     (dl_slot),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.dl_wr       (dl_wr),
		.dl_active   (dl_active),
		.rom_loading (rom_loading),
		.dl_word     (dl_word),
		.dl_din      (dl_din),
		.dl_ds       (dl_ds),
		.dl_we       (dl_we)
	);

	disk_image_detect i_disk_image_detect (
		.clk32        (clk32),
		.rst          (rst),
		.dl_busy      (dl_busy),
		.dl_index     (dl_index),
		.dl_addr      (dl_addr),
		.eject        (eject),
		.inserted     (inserted),
		.double_sided (double_sided)
	);

	reset_stretch i_reset_stretch (
		.clk32           (clk32),
		.rst             (rst),
		.tick            (tick),
		.pll_locked      (pll_locked),
		.osd_reset       (osd_reset),
		.button_reset    (button_reset),
		.rom_loading     (rom_loading),
		.mem_cfg         (mem_cfg),
		.cpu_cfg         (cpu_cfg),
		.cpu_reset_out_n (cpu_reset_out_n),
		.system_reset_n  (system_reset_n)
	);

	bus_ack i_bus_ack (
		.clk32       (clk32),
		.rst         (rst),
		.cpu_reset_n (cpu_reset_n),
		.as_n        (as_n),
		.fc          (fc),
		.area        (area),
		.cpu_slot    (cpu_slot),
		.select_ram  (select_ram),
		.select_rom  (select_rom),
		.turbo       (turbo),
		.en8_p       (en8_p),
		.en8_n       (en8_n),
		.en16_p      (en16_p),
		.en16_n      (en16_n),
		.dtack_n     (dtack_n),
		.vpa_n       (vpa_n),
		.cpu_en_p    (cpu_en_p),
		.cpu_en_n    (cpu_en_n)
	);

	mem_port_mux i_mem_port_mux (
		.dl_active    (dl_active),
		.dl_word      (dl_word),
		.dl_din       (dl_din),
		.dl_ds        (dl_ds),
		.dl_we        (dl_we),
		.mem_word     (mem_word),
		.mem_byte_odd (mem_byte_odd),
		.rom_oe_n     (rom_oe_n),
		.ram_oe_n     (ram_oe_n),
		.ram_we_n     (ram_we_n),
		.uds_n        (uds_n),
		.lds_n        (lds_n),
		.cpu_dout     (cpu_dout),
		.disk_ack     (disk_ack),
		.sdram_dout   (sdram_dout),
		.sdram_addr   (sdram_addr),
		.sdram_din    (sdram_din),
		.sdram_ds     (sdram_ds),
		.sdram_we     (sdram_we),
		.sdram_oe     (sdram_oe),
		.read_data    (read_data)
	);

endmodule

// ==== verif/tb_clock.sv ====
// testbench clock and reset: 100 ns period, reset high for the first five rising edges
`timescale 1ns/1ps

module tb_clock (
	output logic clk32,
	output logic rst
);

	initial begin
		clk32 = 1'b0;
		forever #50 clk32 = ~clk32;
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk32);
		#1 rst = 1'b0; // released on the same 1 ns offset as the stimulus
	end

endmodule

// ==== verif/tb_plus_glue.sv ====
// glue testbench: random stimulus on every block of the core glue, checked against a local model
`timescale 1ns/1ps

module tb_plus_glue;

	// ----------------------------------------------------------------------
	// reference constants of the memory map and bus
	// ----------------------------------------------------------------------
	localparam int          DS_LAST     = 409599; // 819200 byte image
	localparam int          SS_LAST     = 204799; // 409600 byte image
	localparam int          HOLD_TICKS  = 65535;
	localparam logic [24:0] REGION_BASE = 25'h200000; // region 1 above the word space
	localparam int          TEST_CYCLES = 100 + 80 + 60 + 2 * (HOLD_TICKS + 40) + 60 + 100;
	localparam int          WATCHDOG_CYCLES = TEST_CYCLES + 2000;

	logic clk32;
	logic rst;

	logic        dl_busy, dl_slot, dl_wr;
	logic [4:0]  dl_index;
	logic [23:0] dl_addr;
	logic [7:0]  dl_data;
	logic [1:0]  eject, inserted, double_sided;
	logic        tick, pll_locked, osd_reset, button_reset, mem_cfg;
	logic [1:0]  cpu_cfg;
	logic        cpu_reset_out_n, system_reset_n;
	logic        cpu_reset_n, as_n, cpu_slot, select_ram, select_rom, turbo;
	logic [2:0]  fc, area;
	logic        en8_p, en8_n, en16_p, en16_n;
	logic        dtack_n, vpa_n, cpu_en_p, cpu_en_n;
	logic [20:0] mem_word;
	logic        mem_byte_odd, rom_oe_n, ram_oe_n, ram_we_n, uds_n, lds_n;
	logic [15:0] cpu_dout, sdram_dout, sdram_din, read_data;
	logic [1:0]  disk_ack, sdram_ds;
	logic [24:0] sdram_addr;
	logic        sdram_we, sdram_oe;

	int errors;
	int tests_run;
	int tests_failed;

	tb_clock i_clock (
		.clk32 (clk32),
		.rst   (rst)
	);

	plus_glue_top i_dut (.*);

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	task automatic next_cycle();
		@(posedge clk32);
		#1;
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %-16s ok", name);
		end else begin
			tests_failed++;
			$display("test %-16s failed with %0d errors", name, errors - errors_before);
		end
	endtask

	// ----------------------------------------------------------------------
	// 1. byte to word mapping of each download index
	// ----------------------------------------------------------------------
	task automatic download_mapping();
		int          e0;
		logic [20:0] exp_word;
		int          base;
		e0 = errors;
		for (int idx = 0; idx < 3; idx++) begin
			base = (idx == 0) ? 0 : ((idx == 1) ? 32'h80000 : 32'h100000);
			for (int i = 0; i < 24; i++) begin
				next_cycle();
				dl_busy    = 1'b1;
				dl_index   = 5'(idx);
				dl_slot    = ($urandom % 4) != 0;
				dl_addr    = 24'($urandom);
				dl_data    = 8'($urandom);
				sdram_dout = 16'($urandom);
				#10;
				exp_word = 21'(dl_addr / 2 + base);
				if (dl_slot) begin
					check("sdram_addr", 32'(sdram_addr), 32'(REGION_BASE + 25'(exp_word)));
					check("sdram_din", 32'(sdram_din), {16'h0, dl_data, dl_data});
					check("sdram_ds", 32'(sdram_ds), dl_addr[0] ? 32'h1 : 32'h2); // odd is low lane
					check("sdram_we", 32'(sdram_we), 32'h0);
					check("sdram_oe", 32'(sdram_oe), 32'h0);
					check("read_data", 32'(read_data), 32'hffff);
				end else begin
					check("read_data", 32'(read_data), 32'(sdram_dout));
				end
			end
		end
		next_cycle();
		dl_busy = 1'b0;
		dl_slot = 1'b0;
		finish_test("download map", e0);
	endtask

	// ----------------------------------------------------------------------
	// 2. write strobe held through the download cycle
	// ----------------------------------------------------------------------
	task automatic write_strobe_hold();
		int   e0;
		int   len;
		logic late;
		e0 = errors;
		for (int r = 0; r < 6; r++) begin
			next_cycle();
			dl_busy  = 1'b1;
			dl_index = 5'($urandom % 3);
			dl_addr  = 24'($urandom);
			dl_data  = 8'($urandom);
			dl_wr    = 1'b1;
			next_cycle();
			dl_wr = 1'b0;
			len   = 1 + int'($urandom % 3);
			for (int k = 0; k < len; k++) begin
				next_cycle();
				dl_slot = 1'b1;
				#10;
				check("sdram_we", 32'(sdram_we), 32'h1);
			end
			late = 1'($urandom);
			next_cycle();
			dl_slot = 1'b0; // download cycle ends here
			dl_wr   = late; // a byte in this cycle keeps the flag
			#10;
			check("sdram_we", 32'(sdram_we), 32'h0);
			next_cycle();
			dl_wr   = 1'b0;
			dl_slot = 1'b1;
			#10;
			check("sdram_we", 32'(sdram_we), 32'(late));
			next_cycle();
			dl_slot = 1'b0;
			next_cycle();
			dl_busy = 1'b0;
		end
		finish_test("write strobe", e0);
	endtask

	// ----------------------------------------------------------------------
	// 3. image type flags per drive
	// ----------------------------------------------------------------------
	task automatic disk_detection();
		int         e0;
		int         w;
		logic [1:0] m_ds;
		logic [1:0] m_ss;
		e0 = errors;
		next_cycle();
		eject = 2'b11; // start with both drives empty
		next_cycle();
		eject = 2'b00;
		m_ds  = 2'b00;
		m_ss  = 2'b00;
		check("inserted", 32'(inserted), 32'h0);
		for (int d = 0; d < 2; d++) begin
			for (int kind = 0; kind < 3; kind++) begin
				w = (kind == 0) ? DS_LAST : ((kind == 1) ? SS_LAST : int'($urandom % 500000));
				next_cycle();
				dl_busy  = 1'b1;
				dl_index = 5'(d + 1);
				dl_addr  = 24'(w * 2 + int'($urandom % 2));
				next_cycle();
				next_cycle();
				dl_busy = 1'b0;
				check("inserted", 32'(inserted), 32'(m_ds | m_ss)); // not yet
				next_cycle();
				m_ds[d] = (w == DS_LAST);
				m_ss[d] = (w == SS_LAST);
				check("inserted", 32'(inserted), 32'(m_ds | m_ss));
				check("double_sided", 32'(double_sided), 32'(m_ds));
				if (kind == 2 || $urandom % 2 == 0) begin
					eject[d] = 1'b1;
					next_cycle();
					eject   = 2'b00;
					m_ds[d] = 1'b0;
					m_ss[d] = 1'b0;
					check("inserted", 32'(inserted), 32'(m_ds | m_ss));
					check("double_sided", 32'(double_sided), 32'(m_ds));
				end
			end
		end
		finish_test("disk detect", e0);
	endtask

	// ----------------------------------------------------------------------
	// 4. reset stretch
	// ----------------------------------------------------------------------
	task automatic apply_source(input int src, input logic on);
		case (src)
			0: pll_locked = ~on;
			1: osd_reset = on;
			2: button_reset = on;
			3: begin
				dl_busy  = on; // rom download
				dl_index = 5'd0;
			end
			4: if (on) mem_cfg = ~mem_cfg;
			5: if (on) cpu_cfg = cpu_cfg + 2'd1;
			default: cpu_reset_out_n = ~on;
		endcase
	endtask

	task automatic reset_stretching();
		int e0;
		int src;
		int hold;
		int n;
		e0 = errors;
		for (int r = 0; r < 2; r++) begin
			next_cycle();
			tick = 1'b1;
			src  = int'($urandom % 7);
			hold = (src == 4 || src == 5) ? 1 : 1 + int'($urandom % 4); // cfg change lasts one tick
			apply_source(src, 1'b1);
			for (int k = 0; k < hold; k++) begin
				next_cycle();
				check("system_reset_n", 32'(system_reset_n), 32'h0);
			end
			apply_source(src, 1'b0);
			n = 1; // the last edge that saw the source
			while (!system_reset_n && n <= HOLD_TICKS + 20) begin
				next_cycle();
				n++;
			end
			if (!system_reset_n) begin
				$display("system_reset_n did not rise within %0d ticks of source %0d", n, src);
				errors++;
			end else begin
				check("reset ticks", 32'(n), 32'(HOLD_TICKS + 1));
			end
		end
		tick = 1'b0;
		finish_test("reset stretch", e0);
	endtask

	// ----------------------------------------------------------------------
	// 5. cpu request and disk read data
	// ----------------------------------------------------------------------
	task automatic cpu_port_mux();
		int          e0;
		logic [24:0] exp_addr;
		logic [15:0] exp_read;
		e0 = errors;
		for (int i = 0; i < 40; i++) begin
			next_cycle();
			mem_word     = 21'($urandom);
			mem_byte_odd = 1'($urandom);
			rom_oe_n     = 1'($urandom);
			ram_oe_n     = 1'($urandom);
			ram_we_n     = 1'($urandom);
			uds_n        = 1'($urandom);
			lds_n        = 1'($urandom);
			cpu_dout     = 16'($urandom);
			sdram_dout   = 16'($urandom);
			disk_ack     = (i % 2 == 0) ? 2'(1 + $urandom % 3) : 2'b00;
			#10;
			exp_addr = rom_oe_n ? 25'(mem_word) : REGION_BASE + 25'(mem_word);
			if (disk_ack == 2'b00)
				exp_read = sdram_dout;
			else if (mem_byte_odd)
				exp_read = {sdram_dout[7:0], sdram_dout[7:0]};
			else
				exp_read = {sdram_dout[15:8], sdram_dout[15:8]};
			check("sdram_addr", 32'(sdram_addr), 32'(exp_addr));
			check("sdram_din", 32'(sdram_din), 32'(cpu_dout));
			check("sdram_ds", 32'(sdram_ds), 32'({!uds_n, !lds_n}));
			check("sdram_we", 32'(sdram_we), 32'(!ram_we_n));
			check("sdram_oe", 32'(sdram_oe), 32'(!ram_oe_n || !rom_oe_n));
			check("read_data", 32'(read_data), 32'(exp_read));
		end
		next_cycle();
		rom_oe_n = 1'b1;
		ram_oe_n = 1'b1;
		ram_we_n = 1'b1;
		disk_ack = 2'b00;
		finish_test("memory mux", e0);
	endtask

	// ----------------------------------------------------------------------
	// 6. DTACK, VPA and turbo
	// ----------------------------------------------------------------------
	task automatic bus_acknowledge();
		int   e0;
		logic m_en;
		logic m_speed;
		logic m_slot_d;
		logic bus_cycle;
		e0       = errors;
		m_en     = 1'b0;
		m_speed  = 1'b0;
		m_slot_d = 1'b0;
		for (int i = 0; i < 90; i++) begin
			next_cycle();
			// model registers take the inputs of the cycle that just ended
			if (as_n)
				m_en = 1'b0;
			else if ((cpu_slot && !m_slot_d) || (!select_ram && !select_rom))
				m_en = 1'b1;
			if (as_n && en8_n && en16_n)
				m_speed = turbo;
			m_slot_d = cpu_slot;

			turbo      = (i >= 30);
			as_n       = ($urandom % 3) == 0;
			fc         = ($urandom % 5 == 0) ? 3'd7 : 3'($urandom % 7);
			area       = ($urandom % 5 == 0) ? 3'd7 : 3'($urandom % 7);
			cpu_slot   = ($urandom % 4) == 0;
			select_ram = 1'($urandom);
			select_rom = 1'($urandom);
			en8_p      = 1'($urandom);
			en8_n      = 1'($urandom);
			en16_p     = 1'($urandom);
			en16_n     = 1'($urandom);
			#10;
			bus_cycle = !as_n && area != 3'd7 && fc != 3'd7;
			check("vpa_n", 32'(vpa_n), 32'(!(fc == 3'd7 || (!as_n && area == 3'd7))));
			check("dtack_n", 32'(dtack_n), 32'(!bus_cycle || (turbo && !m_en)));
			check("cpu_en_p", 32'(cpu_en_p), 32'(m_speed ? en16_p : en8_p));
			check("cpu_en_n", 32'(cpu_en_n), 32'(m_speed ? en16_n : en8_n));
		end
		next_cycle();
		as_n = 1'b1;
		finish_test("bus acknowledge", e0);
	endtask

	// ----------------------------------------------------------------------
	// run
	// ----------------------------------------------------------------------
	initial begin
		void'($urandom(55));
		errors          = 0;
		tests_run       = 0;
		tests_failed    = 0;
		dl_busy         = 1'b0;
		dl_slot         = 1'b0;
		dl_wr           = 1'b0;
		dl_index        = 5'd0;
		dl_addr         = 24'd0;
		dl_data         = 8'd0;
		eject           = 2'b00;
		tick            = 1'b0;
		pll_locked      = 1'b1;
		osd_reset       = 1'b0;
		button_reset    = 1'b0;
		mem_cfg         = 1'b0;
		cpu_cfg         = 2'd0;
		cpu_reset_out_n = 1'b1;
		cpu_reset_n     = 1'b1;
		as_n            = 1'b1;
		fc              = 3'd0;
		area            = 3'd0;
		cpu_slot        = 1'b0;
		select_ram      = 1'b0;
		select_rom      = 1'b0;
		turbo           = 1'b0;
		en8_p           = 1'b0;
		en8_n           = 1'b0;
		en16_p          = 1'b0;
		en16_n          = 1'b0;
		mem_word        = 21'd0;
		mem_byte_odd    = 1'b0;
		rom_oe_n        = 1'b1;
		ram_oe_n        = 1'b1;
		ram_we_n        = 1'b1;
		uds_n           = 1'b1;
		lds_n           = 1'b1;
		cpu_dout        = 16'd0;
		disk_ack        = 2'b00;
		sdram_dout      = 16'd0;
		@(negedge rst);

		download_mapping();
		write_strobe_hold();
		disk_detection();
		reset_stretching();
		cpu_port_mux();
		bus_acknowledge();

		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// watchdog sized from the test lengths
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk32);
		$display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("Some tests failed");
		$finish;
	end

endmodule

// ==== list.f ====
src/mem_map_pkg.sv
src/cpu_bus_pkg.sv
src/download_port.sv
src/disk_image_detect.sv
src/reset_stretch.sv
src/bus_ack.sv
src/mem_port_mux.sv
src/plus_glue_top.sv
verif/tb_clock.sv
verif/tb_plus_glue.sv

// ==== Makefile ====
# Verilator build for the glue testbench

VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
TOP        = tb_plus_glue
RTL_TOP    = plus_glue_top
FILELIST   = list.f
OBJDIR     = obj_dir
PASS_MSG   = All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -cF "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJDIR)
